/* rtl/soc_pkg.sv */
// bus fabric definitions shared by the arbiter, decoder and targets
// word and address types, address map, memory depths, GPIO register offsets
package soc_pkg;

	typedef logic [31:0] word_t;
	// byte address, bits 1:0 never take part in a decode
	typedef logic [31:0] addr_t;

	typedef enum logic [1:0] {
		HOST_NONE = 2'd0,
		HOST_0    = 2'd1,
		HOST_1    = 2'd2
	} host_t;

	typedef enum logic [2:0] {
		REGION_MAIN    = 3'd0,
		REGION_BOOT    = 3'd1,
		REGION_SCRATCH = 3'd2,
		REGION_GPIO    = 3'd3,
		REGION_NONE    = 3'd4
	} region_t;

	// region bases, only the top byte is compared
	localparam addr_t MAIN_BASE    = 32'h0000_0000;
	localparam addr_t BOOT_BASE    = 32'hF000_0000;
	localparam addr_t SCRATCH_BASE = 32'hF100_0000;
	localparam addr_t GPIO_BASE    = 32'hF200_0000;

	// depths in words, as log2
	localparam int MAIN_DEPTH_BITS    = 10;
	localparam int BOOT_DEPTH_BITS    = 4;
	localparam int SCRATCH_DEPTH_BITS = 8;

	// gpio word offsets, 16 slots with the upper ones unused
	localparam int GPIO_OFF_W = 4;
	localparam logic [GPIO_OFF_W-1:0] GPIO_LED = 4'd0;
	localparam logic [GPIO_OFF_W-1:0] GPIO_IN  = 4'd1;
	localparam logic [GPIO_OFF_W-1:0] GPIO_IE  = 4'd2;
	localparam logic [GPIO_OFF_W-1:0] GPIO_IS  = 4'd3;

	localparam int LED_W = 4;
	localparam int SW_W  = 2;
	localparam int BTN_W = 2;

	localparam word_t BUS_ERR_WORD = 32'hDEAD_BEEF;
	localparam string BOOT_INIT_FILE = "boot.hex";

endpackage

/* rtl/bus_arbiter.sv */
// two-host fixed-priority bus arbiter
// host 0 wins a tie; the owner keeps the bus until it drops req
`timescale 1ns/1ps

module bus_arbiter import soc_pkg::*; (
	input  logic  clk_main,
	input  logic  i_rst,

	input  logic  i_h0_req,
	input  logic  i_h1_req,
	input  addr_t i_h0_addr,
	input  addr_t i_h1_addr,
	input  word_t i_h0_wdata,
	input  word_t i_h1_wdata,
	input  logic  i_h0_we,
	input  logic  i_h1_we,
	input  logic  i_h0_rd,
	input  logic  i_h1_rd,
	output logic  o_h0_gnt,
	output logic  o_h1_gnt,
	output word_t o_h0_rdata,
	output word_t o_h1_rdata,
	output logic  o_h0_ready,
	output logic  o_h1_ready,

	output addr_t o_bus_addr,
	output word_t o_bus_wdata,
	output logic  o_bus_we,
	output logic  o_bus_rd,
	input  word_t i_bus_rdata,
	input  logic  i_bus_ready
);

	host_t owner;
	host_t owner_d;

	// a release always passes through HOST_NONE for one cycle
	always_comb begin
		owner_d = owner;
		case (owner)
			HOST_NONE: begin
				if (i_h0_req)
					owner_d = HOST_0;
				else if (i_h1_req)
					owner_d = HOST_1;
			end
			HOST_0: if (!i_h0_req) owner_d = HOST_NONE;
			HOST_1: if (!i_h1_req) owner_d = HOST_NONE;
			default: owner_d = HOST_NONE;
		endcase
	end

	always_ff @(posedge clk_main) begin
		if (i_rst)
			owner <= HOST_NONE;
		else
			owner <= owner_d;
	end

	assign o_h0_gnt = (owner == HOST_0);
	assign o_h1_gnt = (owner == HOST_1);

	// owner's request onto the bus, strobes held low when idle
	always_comb begin
		o_bus_addr  = '0;
		o_bus_wdata = '0;
		o_bus_we    = 1'b0;
		o_bus_rd    = 1'b0;
		if (o_h0_gnt) begin
			o_bus_addr  = i_h0_addr;
			o_bus_wdata = i_h0_wdata;
			o_bus_we    = i_h0_we;
			o_bus_rd    = i_h0_rd;
		end else if (o_h1_gnt) begin
			o_bus_addr  = i_h1_addr;
			o_bus_wdata = i_h1_wdata;
			o_bus_we    = i_h1_we;
			o_bus_rd    = i_h1_rd;
		end
	end

	assign o_h0_rdata = o_h0_gnt ? i_bus_rdata : '0;
	assign o_h1_rdata = o_h1_gnt ? i_bus_rdata : '0;
	assign o_h0_ready = o_h0_gnt & i_bus_ready;
	assign o_h1_ready = o_h1_gnt & i_bus_ready;

	// no direct handover, the bus is idle for a cycle in between
	a_gnt_handover: assert property (@(posedge clk_main) disable iff (i_rst)
		(o_h0_gnt |=> !o_h1_gnt) and (o_h1_gnt |=> !o_h0_gnt));

endmodule

/* rtl/addr_decoder.sv */
// address decoder for the shared bus
// issues one target access per strobe and returns data with ready a cycle later
`timescale 1ns/1ps

module addr_decoder import soc_pkg::*; (
	input  logic                          clk_main,
	input  logic                          i_rst,
	input  addr_t                         i_addr,
	input  word_t                         i_wdata,
	input  logic                          i_we,
	input  logic                          i_rd,
	output word_t                         o_rdata,
	output logic                          o_ready,

	output logic [MAIN_DEPTH_BITS-1:0]    o_main_idx,
	output logic                          o_main_we,
	output logic                          o_main_rd,
	input  word_t                         i_main_rdata,

	output logic [BOOT_DEPTH_BITS-1:0]    o_boot_idx,
	output logic                          o_boot_rd,
	input  word_t                         i_boot_rdata,

	output logic [SCRATCH_DEPTH_BITS-1:0] o_scr_idx,
	output logic                          o_scr_we,
	output logic                          o_scr_rd,
	input  word_t                         i_scr_rdata,

	output logic [GPIO_OFF_W-1:0]         o_gpio_off,
	output logic                          o_gpio_we,
	output logic                          o_gpio_rd,
	input  word_t                         i_gpio_rdata,

	output word_t                         o_wdata
);

	region_t region;
	region_t region_q;
	logic    pending;
	logic    accept;

	always_comb begin
		case (i_addr[31:24])
			MAIN_BASE[31:24]:    region = REGION_MAIN;
			BOOT_BASE[31:24]:    region = REGION_BOOT;
			SCRATCH_BASE[31:24]: region = REGION_SCRATCH;
			GPIO_BASE[31:24]:    region = REGION_GPIO;
			default:             region = REGION_NONE;
		endcase
	end

	// new strobe while idle, later cycles of the same strobe are ignored
	assign accept = (i_rd | i_we) & ~pending;

	assign o_main_idx = i_addr[MAIN_DEPTH_BITS+1:2];
	assign o_boot_idx = i_addr[BOOT_DEPTH_BITS+1:2];
	assign o_scr_idx  = i_addr[SCRATCH_DEPTH_BITS+1:2];
	assign o_gpio_off = i_addr[GPIO_OFF_W+1:2];
	assign o_wdata    = i_wdata;

	// boot ROM and unmapped writes go nowhere but are still acked
	assign o_main_we = accept & i_we & (region == REGION_MAIN);
	assign o_main_rd = accept & i_rd & (region == REGION_MAIN);
	assign o_boot_rd = accept & i_rd & (region == REGION_BOOT);
	assign o_scr_we  = accept & i_we & (region == REGION_SCRATCH);
	assign o_scr_rd  = accept & i_rd & (region == REGION_SCRATCH);
	assign o_gpio_we = accept & i_we & (region == REGION_GPIO);
	assign o_gpio_rd = accept & i_rd & (region == REGION_GPIO);

	always_ff @(posedge clk_main) begin
		if (i_rst)
			pending <= 1'b0;
		else
			pending <= accept;
	end

	always_ff @(posedge clk_main) begin
		if (accept)
			region_q <= region;
	end

	// every target answers one cycle after its strobe
	assign o_ready = pending;

	always_comb begin
		case (region_q)
			REGION_MAIN:    o_rdata = i_main_rdata;
			REGION_BOOT:    o_rdata = i_boot_rdata;
			REGION_SCRATCH: o_rdata = i_scr_rdata;
			REGION_GPIO:    o_rdata = i_gpio_rdata;
			default:        o_rdata = BUS_ERR_WORD;
		endcase
	end

	// the host holds an accepted strobe and its address into the ready cycle
	a_ready_follows_strobe: assert property (@(posedge clk_main) disable iff (i_rst)
		accept |=> o_ready && (i_rd || i_we) && $stable(i_addr));

endmodule

/* rtl/word_ram.sv */
// single-port word RAM, read data registered one cycle after the strobe
`timescale 1ns/1ps

module word_ram import soc_pkg::*; #(
	parameter int DEPTH_BITS = 8
) (
	input  logic                  clk_main,
	input  logic [DEPTH_BITS-1:0] i_idx,
	input  word_t                 i_wdata,
	input  logic                  i_we,
	input  logic                  i_rd,
	output word_t                 o_rdata
);

	localparam int DEPTH = 1 << DEPTH_BITS;

	word_t mem [DEPTH];

	always_ff @(posedge clk_main) begin
		if (i_we)
			mem[i_idx] <= i_wdata;
	end

	// holds the last read between strobes
	always_ff @(posedge clk_main) begin
		if (i_rd)
			o_rdata <= mem[i_idx];
	end

endmodule

/* rtl/boot_rom.sv */
// boot ROM loaded from the boot image, registered read
`timescale 1ns/1ps

module boot_rom import soc_pkg::*; (
	input  logic                       clk_main,
	input  logic [BOOT_DEPTH_BITS-1:0] i_idx,
	input  logic                       i_rd,
	output word_t                      o_rdata
);

	word_t rom [1 << BOOT_DEPTH_BITS];

	initial begin
		$readmemh(BOOT_INIT_FILE, rom);
	end

	always_ff @(posedge clk_main) begin
		if (i_rd)
			o_rdata <= rom[i_idx];
	end

endmodule

/* rtl/gpio_regs.sv */
// GPIO register block: LEDs, switch and button inputs
// button-change interrupt with enable and write-one-to-clear status
`timescale 1ns/1ps

module gpio_regs import soc_pkg::*; (
	input  logic                  clk_main,
	input  logic                  i_rst,
	input  logic [GPIO_OFF_W-1:0] i_off,
	input  word_t                 i_wdata,
	input  logic                  i_we,
	input  logic                  i_rd,
	input  logic [SW_W-1:0]       i_sw,
	input  logic [BTN_W-1:0]      i_btn,
	output word_t                 o_rdata,
	output logic [LED_W-1:0]      o_led,
	output logic                  o_irq
);

	logic [LED_W-1:0] led_q;
	logic [BTN_W-1:0] btn_q;
	logic             irq_en;
	logic             irq_stat;

	always_ff @(posedge clk_main) begin
		if (i_rst) begin
			led_q    <= '0;
			irq_en   <= 1'b0;
			irq_stat <= 1'b0;
		end else begin
			if (i_we && i_off == GPIO_LED)
				led_q <= i_wdata[LED_W-1:0];
			if (i_we && i_off == GPIO_IE)
				irq_en <= i_wdata[0];
			if (i_we && i_off == GPIO_IS && i_wdata[0])
				irq_stat <= 1'b0;
			// a new edge wins over a clear in the same cycle
			if (irq_en && i_btn != btn_q)
				irq_stat <= 1'b1;
		end
	end

	// last seen buttons, for change detection
	always_ff @(posedge clk_main) begin
		btn_q <= i_btn;
	end

	always_ff @(posedge clk_main) begin
		if (i_rd) begin
			case (i_off)
				GPIO_LED: o_rdata <= word_t'(led_q);
				GPIO_IN:  o_rdata <= word_t'({i_btn, i_sw});
				GPIO_IE:  o_rdata <= word_t'(irq_en);
				GPIO_IS:  o_rdata <= word_t'(irq_stat);
				default:  o_rdata <= BUS_ERR_WORD;
			endcase
		end
	end

	assign o_led = led_q;
	assign o_irq = irq_stat;

endmodule

/* rtl/soc_top.sv */
// bus fabric top: two hosts share main RAM, boot ROM, scratch RAM and GPIO
`timescale 1ns/1ps

module soc_top import soc_pkg::*; (
	input  logic             clk_main,
	input  logic             i_rst,

	input  logic             i_h0_req,
	input  addr_t            i_h0_addr,
	input  word_t            i_h0_wdata,
	input  logic             i_h0_we,
	input  logic             i_h0_rd,
	output logic             o_h0_gnt,
	output word_t            o_h0_rdata,
	output logic             o_h0_ready,

	input  logic             i_h1_req,
	input  addr_t            i_h1_addr,
	input  word_t            i_h1_wdata,
	input  logic             i_h1_we,
	input  logic             i_h1_rd,
	output logic             o_h1_gnt,
	output word_t            o_h1_rdata,
	output logic             o_h1_ready,

	input  logic [SW_W-1:0]  i_sw,
	input  logic [BTN_W-1:0] i_btn,
	output logic [LED_W-1:0] o_led,
	output logic             o_gpio_irq
);

	// shared bus after the arbiter
	addr_t bus_addr;
	word_t bus_wdata;
	logic  bus_we;
	logic  bus_rd;
	word_t bus_rdata;
	logic  bus_ready;

	// decoder to targets
	word_t                         tgt_wdata;
	logic [MAIN_DEPTH_BITS-1:0]    main_idx;
	logic                          main_we;
	logic                          main_rd;
	word_t                         main_rdata;
	logic [BOOT_DEPTH_BITS-1:0]    boot_idx;
	logic                          boot_rd;
	word_t                         boot_rdata;
	logic [SCRATCH_DEPTH_BITS-1:0] scr_idx;
	logic                          scr_we;
	logic                          scr_rd;
	word_t                         scr_rdata;
	logic [GPIO_OFF_W-1:0]         gpio_off;
	logic                          gpio_we;
	logic                          gpio_rd;
	word_t                         gpio_rdata;

	bus_arbiter i_bus_arbiter (
		.clk_main    (clk_main),
		.i_rst       (i_rst),
		.i_h0_req    (i_h0_req),
		.i_h1_req    (i_h1_req),
		.i_h0_addr   (i_h0_addr),
		.i_h1_addr   (i_h1_addr),
		.i_h0_wdata  (i_h0_wdata),
		.i_h1_wdata  (i_h1_wdata),
		.i_h0_we     (i_h0_we),
		.i_h1_we     (i_h1_we),
		.i_h0_rd     (i_h0_rd),
		.i_h1_rd     (i_h1_rd),
		.o_h0_gnt    (o_h0_gnt),
		.o_h1_gnt    (o_h1_gnt),
		.o_h0_rdata  (o_h0_rdata),
		.o_h1_rdata  (o_h1_rdata),
		.o_h0_ready  (o_h0_ready),
		.o_h1_ready  (o_h1_ready),
		.o_bus_addr  (bus_addr),
		.o_bus_wdata (bus_wdata),
		.o_bus_we    (bus_we),
		.o_bus_rd    (bus_rd),
		.i_bus_rdata (bus_rdata),
		.i_bus_ready (bus_ready)
	);

	addr_decoder i_addr_decoder (
		.clk_main     (clk_main),
		.i_rst        (i_rst),
		.i_addr       (bus_addr),
		.i_wdata      (bus_wdata),
		.i_we         (bus_we),
		.i_rd         (bus_rd),
		.o_rdata      (bus_rdata),
		.o_ready      (bus_ready),
		.o_main_idx   (main_idx),
		.o_main_we    (main_we),
		.o_main_rd    (main_rd),
		.i_main_rdata (main_rdata),
		.o_boot_idx   (boot_idx),
		.o_boot_rd    (boot_rd),
		.i_boot_rdata (boot_rdata),
		.o_scr_idx    (scr_idx),
		.o_scr_we     (scr_we),
		.o_scr_rd     (scr_rd),
		.i_scr_rdata  (scr_rdata),
		.o_gpio_off   (gpio_off),
		.o_gpio_we    (gpio_we),
		.o_gpio_rd    (gpio_rd),
		.i_gpio_rdata (gpio_rdata),
		.o_wdata      (tgt_wdata)
	);

	word_ram #(.DEPTH_BITS(MAIN_DEPTH_BITS)) main_mem (
		.clk_main (clk_main),
		.i_idx    (main_idx),
		.i_wdata  (tgt_wdata),
		.i_we     (main_we),
		.i_rd     (main_rd),
		.o_rdata  (main_rdata)
	);

	word_ram #(.DEPTH_BITS(SCRATCH_DEPTH_BITS)) scratch_mem (
		.clk_main (clk_main),
		.i_idx    (scr_idx),
		.i_wdata  (tgt_wdata),
		.i_we     (scr_we),
		.i_rd     (scr_rd),
		.o_rdata  (scr_rdata)
	);

	boot_rom i_boot_rom (
		.clk_main (clk_main),
		.i_idx    (boot_idx),
		.i_rd     (boot_rd),
		.o_rdata  (boot_rdata)
	);

	gpio_regs i_gpio_regs (
		.clk_main (clk_main),
		.i_rst    (i_rst),
		.i_off    (gpio_off),
		.i_wdata  (tgt_wdata),
		.i_we     (gpio_we),
		.i_rd     (gpio_rd),
		.i_sw     (i_sw),
		.i_btn    (i_btn),
		.o_rdata  (gpio_rdata),
		.o_led    (o_led),
		.o_irq    (o_gpio_irq)
	);

endmodule

/* test/tb_clock.sv */
// testbench clock and reset source
// 8 ns clk_main, reset held high for the first 5 rising edges
`timescale 1ns/1ps

module tb_clock (
	output logic o_clk_main,
	output logic o_rst
);

	initial begin
		o_clk_main = 1'b0;
		forever #4 o_clk_main = ~o_clk_main;
	end

	initial begin
		o_rst <= 1'b1;
		repeat (5) @(posedge o_clk_main);
		o_rst <= 1'b0;
	end

endmodule

/* test/soc_tb.sv */
// testbench for the two-host bus fabric
// directed tests over memories, boot ROM, arbitration, GPIO and unmapped space
`timescale 1ns/1ps

module soc_tb import soc_pkg::*; ();

	// about 100 bus accesses of roughly 6 cycles each, so 3000 leaves ample margin
	localparam int MAX_CYCLES = 3000;

	logic             clk_main;
	logic             rst;
	logic             h0_req;
	addr_t            h0_addr;
	word_t            h0_wdata;
	logic             h0_we;
	logic             h0_rd;
	logic             h0_gnt;
	word_t            h0_rdata;
	logic             h0_ready;
	logic             h1_req;
	addr_t            h1_addr;
	word_t            h1_wdata;
	logic             h1_we;
	logic             h1_rd;
	logic             h1_gnt;
	word_t            h1_rdata;
	logic             h1_ready;
	logic [SW_W-1:0]  sw;
	logic [BTN_W-1:0] btn;
	logic [LED_W-1:0] o_led;
	logic             o_gpio_irq;

	integer seed = 32'hc29ee194;
	int     cycles = 0;

	// expected contents of the memories
	word_t main_model [1 << MAIN_DEPTH_BITS];
	word_t scr_model  [1 << SCRATCH_DEPTH_BITS];
	word_t rom_image  [1 << BOOT_DEPTH_BITS];

	tb_clock i_tb_clock (
		.o_clk_main (clk_main),
		.o_rst      (rst)
	);

	soc_top i_soc_top (
		.clk_main   (clk_main),
		.i_rst      (rst),
		.i_h0_req   (h0_req),
		.i_h0_addr  (h0_addr),
		.i_h0_wdata (h0_wdata),
		.i_h0_we    (h0_we),
		.i_h0_rd    (h0_rd),
		.o_h0_gnt   (h0_gnt),
		.o_h0_rdata (h0_rdata),
		.o_h0_ready (h0_ready),
		.i_h1_req   (h1_req),
		.i_h1_addr  (h1_addr),
		.i_h1_wdata (h1_wdata),
		.i_h1_we    (h1_we),
		.i_h1_rd    (h1_rd),
		.o_h1_gnt   (h1_gnt),
		.o_h1_rdata (h1_rdata),
		.o_h1_ready (h1_ready),
		.i_sw       (sw),
		.i_btn      (btn),
		.o_led      (o_led),
		.o_gpio_irq (o_gpio_irq)
	);

	task automatic stop_on_failure();
		$display("TEST FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
			stop_on_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("MISMATCH at %0t: %s expected %b, got %b", $time, name, expected, actual);
			stop_on_failure();
		end
	endtask

	function automatic logic gnt_of(input int host);
		return (host == 0) ? h0_gnt : h1_gnt;
	endfunction

	function automatic logic ready_of(input int host);
		return (host == 0) ? h0_ready : h1_ready;
	endfunction

	function automatic word_t rdata_of(input int host);
		return (host == 0) ? h0_rdata : h1_rdata;
	endfunction

	task automatic drive_req(input int host, input logic value);
		if (host == 0)
			h0_req <= value;
		else
			h1_req <= value;
	endtask

	task automatic drive_strobe(input int host, input logic rd, input logic we,
		input addr_t addr, input word_t wdata);
		if (host == 0) begin
			h0_rd    <= rd;
			h0_we    <= we;
			h0_addr  <= addr;
			h0_wdata <= wdata;
		end else begin
			h1_rd    <= rd;
			h1_we    <= we;
			h1_addr  <= addr;
			h1_wdata <= wdata;
		end
	endtask

	task automatic wait_grant(input int host);
		@(negedge clk_main);
		while (!gnt_of(host))
			@(negedge clk_main);
	endtask

	// one full access: request, strobe until ready, then release
	task automatic bus_access(input int host, input logic is_write, input addr_t addr,
		input word_t wdata, output word_t rdata);
		int waited;
		waited = 0;
		@(posedge clk_main);
		drive_req(host, 1'b1);
		wait_grant(host);
		@(posedge clk_main);
		drive_strobe(host, !is_write, is_write, addr, wdata);
		@(negedge clk_main);
		while (!ready_of(host)) begin
			waited = waited + 1;
			@(negedge clk_main);
		end
		if (waited != 1) begin
			$display("host %0d: ready came %0d cycles after the strobe instead of 1",
				host, waited);
			stop_on_failure();
		end
		rdata = rdata_of(host);
		@(posedge clk_main);
		drive_strobe(host, 1'b0, 1'b0, addr, wdata);
		drive_req(host, 1'b0);
		// ready lasts a single cycle
		@(negedge clk_main);
		check_bit($sformatf("o_h%0d_ready", host), 1'b0, ready_of(host));
	endtask

	task automatic bus_write(input int host, input addr_t addr, input word_t data);
		word_t unused;
		bus_access(host, 1'b1, addr, data, unused);
	endtask

	task automatic bus_read(input int host, input addr_t addr, output word_t data);
		bus_access(host, 1'b0, addr, '0, data);
	endtask

	task automatic after_reset();
		check_bit("o_h0_gnt", 1'b0, h0_gnt);
		check_bit("o_h1_gnt", 1'b0, h1_gnt);
		check_bit("o_h0_ready", 1'b0, h0_ready);
		check_bit("o_h1_ready", 1'b0, h1_ready);
		check_word("o_led", '0, word_t'(o_led));
		check_bit("o_gpio_irq", 1'b0, o_gpio_irq);
	endtask

	task automatic memory_readback();
		logic [4:0]                    n;
		logic [MAIN_DEPTH_BITS-1:0]    midx;
		logic [SCRATCH_DEPTH_BITS-1:0] sidx;
		logic [MAIN_DEPTH_BITS-1:0]    main_used [$];
		logic [SCRATCH_DEPTH_BITS-1:0] scr_used [$];
		word_t                         rnd;
		word_t                         data;
		word_t                         got;
		// random low address bits on writes, bits 1:0 are not decoded
		for (n = 5'd0; n < 5'd16; n = n + 5'd1) begin
			rnd = $random(seed);
			midx = {n[3:0], rnd[5:0]};
			data = $random(seed);
			main_model[midx] = data;
			main_used.push_back(midx);
			bus_write(0, MAIN_BASE | addr_t'({midx, rnd[7:6]}), data);
			sidx = {n[3:0], rnd[11:8]};
			data = $random(seed);
			scr_model[sidx] = data;
			scr_used.push_back(sidx);
			bus_write(1, SCRATCH_BASE | addr_t'({sidx, rnd[13:12]}), data);
		end
		while (main_used.size() > 0) begin
			midx = main_used.pop_front();
			bus_read(0, MAIN_BASE | addr_t'({midx, 2'b00}), got);
			check_word("o_h0_rdata", main_model[midx], got);
		end
		while (scr_used.size() > 0) begin
			sidx = scr_used.pop_front();
			bus_read(1, SCRATCH_BASE | addr_t'({sidx, 2'b00}), got);
			check_word("o_h1_rdata", scr_model[sidx], got);
		end
	endtask

	task automatic boot_rom_reads();
		logic [4:0] n;
		word_t      got;
		for (n = 5'd0; n < 5'd16; n = n + 5'd1) begin
			bus_read(0, BOOT_BASE | addr_t'({n[3:0], 2'b00}), got);
			check_word("o_h0_rdata", rom_image[n[3:0]], got);
		end
		// write is acked but the ROM keeps its word
		bus_write(1, BOOT_BASE | 32'h14, ~rom_image[5]);
		bus_read(1, BOOT_BASE | 32'h14, got);
		check_word("o_h1_rdata", rom_image[5], got);
	endtask

	task automatic arbitration();
		word_t d0;
		word_t d1;
		word_t got;
		d0 = $random(seed);
		d1 = $random(seed);
		@(posedge clk_main);
		drive_req(0, 1'b1);
		drive_req(1, 1'b1);
		@(negedge clk_main);
		while (!h0_gnt && !h1_gnt)
			@(negedge clk_main);
		check_bit("o_h0_gnt", 1'b1, h0_gnt);
		check_bit("o_h1_gnt", 1'b0, h1_gnt);
		// host 1 keeps waiting while host 0 holds req
		repeat (3) begin
			@(negedge clk_main);
			check_bit("o_h1_gnt", 1'b0, h1_gnt);
		end
		main_model[10'h3ff] = d0;
		bus_write(0, MAIN_BASE | 32'hffc, d0);
		wait_grant(1);
		check_bit("o_h0_gnt", 1'b0, h0_gnt);
		scr_model[8'hff] = d1;
		bus_write(1, SCRATCH_BASE | 32'h3fc, d1);
		bus_read(1, SCRATCH_BASE | 32'h3fc, got);
		check_word("o_h1_rdata", scr_model[8'hff], got);
		bus_read(0, MAIN_BASE | 32'hffc, got);
		check_word("o_h0_rdata", main_model[10'h3ff], got);
	endtask

	task automatic gpio_pins();
		word_t rnd;
		word_t got;
		rnd = $random(seed);
		bus_write(0, GPIO_BASE | addr_t'({GPIO_LED, 2'b00}), rnd);
		check_word("o_led", word_t'(rnd[LED_W-1:0]), word_t'(o_led));
		bus_read(0, GPIO_BASE | addr_t'({GPIO_LED, 2'b00}), got);
		check_word("o_h0_rdata", word_t'(rnd[LED_W-1:0]), got);
		@(posedge clk_main);
		sw  <= 2'b10;
		btn <= 2'b01;
		// switches in bits 1:0, buttons in bits 3:2
		bus_read(1, GPIO_BASE | addr_t'({GPIO_IN, 2'b00}), got);
		check_word("o_h1_rdata", (word_t'(2'b01) << 2) | word_t'(2'b10), got);
		// change with interrupt disabled stays quiet
		@(posedge clk_main);
		btn <= 2'b11;
		repeat (2) @(negedge clk_main);
		check_bit("o_gpio_irq", 1'b0, o_gpio_irq);
		bus_write(0, GPIO_BASE | addr_t'({GPIO_IE, 2'b00}), 32'h1);
		check_bit("o_gpio_irq", 1'b0, o_gpio_irq);
		@(posedge clk_main);
		btn <= 2'b01;
		repeat (2) @(negedge clk_main);
		check_bit("o_gpio_irq", 1'b1, o_gpio_irq);
		bus_read(1, GPIO_BASE | addr_t'({GPIO_IS, 2'b00}), got);
		check_word("o_h1_rdata", 32'h1, got);
		bus_write(1, GPIO_BASE | addr_t'({GPIO_IS, 2'b00}), 32'h1);
		check_bit("o_gpio_irq", 1'b0, o_gpio_irq);
		bus_read(0, GPIO_BASE | addr_t'({GPIO_IE, 2'b00}), got);
		check_word("o_h0_rdata", 32'h1, got);
	endtask

	task automatic unmapped_access();
		word_t got;
		bus_read(0, 32'h8000_0010, got);
		check_word("o_h0_rdata", BUS_ERR_WORD, got);
		bus_write(1, 32'h4000_0000, 32'h1234_5678);
		bus_read(1, 32'h4000_0000, got);
		check_word("o_h1_rdata", BUS_ERR_WORD, got);
		// gpio offset 8 has no register
		bus_read(0, GPIO_BASE | 32'h20, got);
		check_word("o_h0_rdata", BUS_ERR_WORD, got);
	endtask

	always @(negedge clk_main) begin
		if (!rst && h0_gnt && h1_gnt) begin
			$display("both hosts granted in the same cycle at %0t", $time);
			stop_on_failure();
		end
	end

	always @(posedge clk_main) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: tests still running after %0d cycles", cycles);
			stop_on_failure();
		end
	end

	initial begin
		h0_req   <= 1'b0;
		h0_addr  <= '0;
		h0_wdata <= '0;
		h0_we    <= 1'b0;
		h0_rd    <= 1'b0;
		h1_req   <= 1'b0;
		h1_addr  <= '0;
		h1_wdata <= '0;
		h1_we    <= 1'b0;
		h1_rd    <= 1'b0;
		sw       <= '0;
		btn      <= '0;
		$readmemh(BOOT_INIT_FILE, rom_image);
		do
			@(negedge clk_main);
		while (rst);
		after_reset();
		memory_readback();
		boot_rom_reads();
		arbitration();
		gpio_pins();
		unmapped_access();
		$display("TEST PASS");
		$finish;
	end

endmodule

/* boot.hex */
// boot image: one 32-bit word per line in hex, word 0 first
00000297
02028293
30529073
f0000537
00050513
f10005b7
0005a583
00b52023
00458593
fe0008e3
10500073
a5a55a5a
0badc0de
13572468
fedcba98
0000006f

/* project.f */
rtl/soc_pkg.sv
rtl/bus_arbiter.sv
rtl/addr_decoder.sv
rtl/word_ram.sv
rtl/boot_rom.sv
rtl/gpio_regs.sv
rtl/soc_top.sv
test/tb_clock.sv
test/soc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the bus fabric testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module soc_tb -o soc_tb_sim

sim_out=$(./obj_dir/soc_tb_sim 2>&1 || true)
echo "$sim_out"

if echo "$sim_out" | grep -q "^TEST PASS$"; then
	exit 0
fi
exit 1
